//--- Bender.yml
package:
  name: isaExec

sources:
  - logic/isaPkg.sv
  - logic/claAdder.sv
  - logic/barrelShifter.sv
  - logic/execCtrl.sv
  - logic/aluCore.sv
  - logic/execUnit.sv
  - target: test
    files:
      - bench/execUnitTb.sv

//--- bench/execUnitTb.sv
// Execute stage testbench with clock, reset, stimulus, reference model, result queue and checker
module execUnitTb import isaPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rstN;
    logic                  inValid;
    opcodeE                opcode;
    logic [FunctWidth-1:0] funct;
    logic [DataWidth-1:0]  aIn;
    logic [DataWidth-1:0]  bIn;
    logic                  outReady;
    logic                  inReady;
    logic                  outValid;
    logic [DataWidth-1:0]  result;
    logic                  illegal;

    integer             seed = 36;
    int                 errorCount = 0;
    int                 checkCount = 0;
    int                 cycleCount = 0;
    bit                 timeLatency = 1'b0;  // Latency and throughput checked while set
    bit                 randomReady = 1'b0;
    bit                 stallSeen = 1'b0;
    logic [DataWidth:0] heldOut;
    logic [21:0]        expectQ [$];         // Opcode, illegal, result
    int                 acceptQ [$];         // Accept cycle, -1 when untimed
    logic [DataWidth-1:0] cornerA [0:6] = '{16'h1234, 16'h8000, 16'h7FFF, 16'h8000,
                                            16'hFFFF, 16'h7FFF, 16'h0000};
    logic [DataWidth-1:0] cornerB [0:6] = '{16'h1234, 16'h7FFF, 16'h8000, 16'h8000,
                                            16'h0001, 16'h7FFF, 16'hFFFF};

    execUnit UUT (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .opcode   (opcode),
        .funct    (funct),
        .aIn      (aIn),
        .bIn      (bIn),
        .outReady (outReady),
        .inReady  (inReady),
        .outValid (outValid),
        .result   (result),
        .illegal  (illegal)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [DataWidth-1:0] arithValue(input logic [1:0] sel,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        case (sel)
            2'd0:    return a + b;
            2'd1:    return b - a;  // SUB takes A from B
            2'd2:    return a ^ b;
            default: return ~(a & b);
        endcase
    endfunction

    function automatic logic [DataWidth-1:0] shiftValue(input logic [1:0] sel,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [2*DataWidth-1:0] both;
        int                     n;
        n    = b[ShiftWidth-1:0];
        both = {a, a};  // Doubled word gives the wrapped bits
        case (sel)
            2'd0:    return a << n;
            2'd1:    return a >> n;
            2'd2:    return both[2*DataWidth-1-n -: DataWidth];
            default: return both[n +: DataWidth];
        endcase
    endfunction

    // Illegal flag in the top bit, result word below
    function automatic logic [DataWidth:0] expectedOutcome(input logic [4:0] op,
            input logic [1:0] fn, input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        logic [DataWidth:0] wide;
        wide = {1'b0, a} + {1'b0, b};
        case (op[4:2])
            3'b000: return '0;
            3'b010: return {1'b0, arithValue(op[1:0], a, b)};
            3'b101: return {1'b0, shiftValue(op[1:0], a, b)};
            3'b110: begin
                if (!op[1])
                    return {1'b1, {DataWidth{1'b0}}};
                else if (op[0])
                    return {1'b0, arithValue(fn, a, b)};
                else
                    return {1'b0, shiftValue(fn, a, b)};
            end
            3'b111: begin
                case (op[1:0])
                    2'd0:    return {1'b0, DataWidth'(a == b)};
                    2'd1:    return {1'b0, DataWidth'($signed(a) < $signed(b))};
                    2'd2:    return {1'b0, DataWidth'($signed(a) <= $signed(b))};
                    default: return {1'b0, DataWidth'(wide[DataWidth])};
                endcase
            end
            default: return {1'b1, {DataWidth{1'b0}}};  // Jump, branch, memory
        endcase
    endfunction

    function automatic bit knownOpcode(input logic [4:0] op);
        case (op[4:2])
            3'b000:  return op == 5'b00000;
            3'b110:  return op[1];
            default: return 1'b1;
        endcase
    endfunction

    task automatic abortRun(input string why);
        $display("Timeout: %s", why);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic sendInstr(input logic [4:0] op, input logic [1:0] fn,
            input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b);
        int waited;
        waited = 0;
        inValid <= 1'b1;
        opcode  <= opcodeE'(op);
        funct   <= fn;
        aIn     <= a;
        bIn     <= b;
        @(posedge clk);
        while (!inReady) begin
            waited++;
            if (waited > 200)
                abortRun("inReady stayed low, the input handshake stalled");
            @(posedge clk);
        end
        if (timeLatency) begin
            checkCount++;
            if (waited != 0) begin
                errorCount++;
                $display("ERROR at %0t: inReady dropped with outReady held high", $time);
            end
        end
        expectQ.push_back({op, expectedOutcome(op, fn, a, b)});
        acceptQ.push_back(timeLatency ? cycleCount : -1);
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        inValid <= 1'b0;
        while (expectQ.size() != 0) begin
            waited++;
            if (waited > 2000)
                abortRun("outValid never delivered the outstanding results");
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (randomReady)
            outReady <= ($random(seed) & 1) != 0;  // Ready about half the cycles
    end

    always @(posedge clk) begin : compareOut
        logic [21:0] entry;
        int          accepted;
        cycleCount <= cycleCount + 1;
        if (rstN) begin
            if (stallSeen) begin
                checkCount++;
                if (!outValid || {illegal, result} !== heldOut) begin
                    errorCount++;
                    $display("ERROR at %0t: output changed while stalled", $time);
                end
            end
            if (outValid && outReady) begin
                if (expectQ.size() == 0) begin
                    errorCount++;
                    $display("An output transfer arrived with no instruction outstanding");
                end else begin
                    entry    = expectQ.pop_front();
                    accepted = acceptQ.pop_front();
                    checkCount++;
                    if ({illegal, result} !== entry[DataWidth:0]) begin
                        errorCount++;
                        $display("ERROR at %0t: opcode %b gave %b/%h, expected %b/%h", $time,
                                 entry[21:17], illegal, result, entry[16], entry[15:0]);
                    end
                    if (accepted >= 0 && cycleCount - accepted != 2) begin
                        errorCount++;
                        $display("ERROR at %0t: latency %0d cycles, expected 2", $time,
                                 cycleCount - accepted);
                    end
                end
            end
            stallSeen = outValid && !outReady;
            heldOut   = {illegal, result};
        end
    end

    initial begin
        logic [4:0]           op;
        logic [DataWidth-1:0] a;
        logic [DataWidth-1:0] b;
        clk      = 1'b0;
        rstN     = 1'b0;
        inValid  = 1'b0;
        opcode   = opcNop;
        funct    = '0;
        aIn      = '0;
        bIn      = '0;
        outReady = 1'b1;
        repeat (5) begin
            @(posedge clk);
            if (outValid !== 1'b0 || inReady !== 1'b0 || illegal !== 1'b0) begin
                errorCount++;
                $display("ERROR at %0t: outValid, inReady or illegal high during reset", $time);
            end
        end
        rstN <= 1'b1;
        repeat (2) @(posedge clk);
        if (outValid !== 1'b0 || illegal !== 1'b0) begin
            errorCount++;
            $display("ERROR at %0t: outValid or illegal high after reset", $time);
        end
        timeLatency = 1'b1;
        for (int i = 0; i < 16; i++) begin
            for (int k = 0; k < 4; k++) begin
                sendInstr({3'b010, 2'(k)}, 2'b00, $random(seed), $random(seed));
                sendInstr(5'b11011, 2'(k), $random(seed), $random(seed));
            end
        end
        for (int n = 0; n < 16; n++) begin
            for (int k = 0; k < 4; k++) begin
                b                 = $random(seed);
                b[ShiftWidth-1:0] = 4'(n);  // Upper bits stay random
                sendInstr({3'b101, 2'(k)}, 2'b00, $random(seed), b);
                sendInstr(5'b11010, 2'(k), $random(seed), b);
            end
        end
        for (int p = 0; p < 15; p++) begin
            a = (p < 7) ? cornerA[p] : $random(seed);
            b = (p < 7) ? cornerB[p] : $random(seed);
            for (int k = 0; k < 4; k++)
                sendInstr({3'b111, 2'(k)}, 2'b00, a, b);
        end
        sendInstr(5'b00000, 2'b00, $random(seed), $random(seed));
        // Codes 4 to 19 minus class 010 cover jump, branch and memory
        for (int code = 4; code < 20; code++) begin
            if (code < 8 || code >= 12)
                sendInstr(5'(code), 2'($random(seed)), $random(seed), $random(seed));
        end
        waitDrained();
        timeLatency = 1'b0;
        randomReady = 1'b1;
        for (int i = 0; i < 300; i++) begin
            do
                op = $random(seed);
            while (!knownOpcode(op));
            if (($random(seed) & 7) == 0) begin
                inValid <= 1'b0;  // Idle cycle in the stream
                @(posedge clk);
            end
            sendInstr(op, 2'($random(seed)), $random(seed), $random(seed));
        end
        waitDrained();
        randomReady = 1'b0;
        outReady <= 1'b1;
        repeat (5) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- isaExec.f
logic/isaPkg.sv
logic/claAdder.sv
logic/barrelShifter.sv
logic/execCtrl.sv
logic/aluCore.sv
logic/execUnit.sv
bench/execUnitTb.sv

//--- logic/aluCore.sv
// ALU datapath with operand and result registers, adder and shifter steering, logic and compares
module aluCore import isaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 loadOperands,
    input  logic                 loadResult,
    input  aluOpE                aluOp,
    input  logic [DataWidth-1:0] aIn,
    input  logic [DataWidth-1:0] bIn,
    output logic [DataWidth-1:0] result
);

    logic [DataWidth-1:0] aReg;
    logic [DataWidth-1:0] bReg;
    logic [DataWidth-1:0] addA;
    logic [DataWidth-1:0] addB;
    logic                 addCin;
    logic [DataWidth-1:0] addSum;
    logic                 addCout;
    logic                 addOvf;
    shiftModeE            shiftMode;
    logic [DataWidth-1:0] shiftOut;
    logic                 equal;
    logic                 lessThan;
    logic [DataWidth-1:0] aluValue;

    always_ff @(posedge clk) begin
        if (loadOperands) begin
            aReg <= aIn;
            bReg <= bIn;
        end
    end

    always_comb begin
        addA   = aReg;
        addB   = bReg;
        addCin = 1'b0;
        case (aluOp)
            opSub: begin
                addA   = ~aReg;  // B minus A
                addCin = 1'b1;
            end
            opSlt, opSle: begin
                addB   = ~bReg;  // A minus B for signed compare
                addCin = 1'b1;
            end
            default: ;
        endcase
    end

    claAdder adder (
        .inA      (addA),
        .inB      (addB),
        .cIn      (addCin),
        .sum      (addSum),
        .cOut     (addCout),
        .overflow (addOvf)
    );

    always_comb begin
        case (aluOp)
            opSrl:   shiftMode = modeSrl;
            opRol:   shiftMode = modeRol;
            opRor:   shiftMode = modeRor;
            default: shiftMode = modeSll;
        endcase
    end

    barrelShifter shifter (
        .dataIn  (aReg),
        .amount  (bReg[ShiftWidth-1:0]),  // Upper bits of B ignored
        .mode    (shiftMode),
        .dataOut (shiftOut)
    );

    assign equal    = (aReg == bReg);
    assign lessThan = addSum[DataWidth-1] ^ addOvf;  // Sign corrected by overflow

    always_comb begin
        aluValue = '0;
        case (aluOp)
            opAdd, opSub:               aluValue = addSum;
            opXor:                      aluValue = aReg ^ bReg;
            opNand:                     aluValue = ~(aReg & bReg);
            opSll, opSrl, opRol, opRor: aluValue = shiftOut;
            opSeq:                      aluValue = DataWidth'(equal);
            opSlt:                      aluValue = DataWidth'(lessThan);
            opSle:                      aluValue = DataWidth'(lessThan | equal);
            opSco:                      aluValue = DataWidth'(addCout);
            default:                    aluValue = '0;  // NOP and illegal
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (loadResult) begin
            result <= aluValue;
        end
    end

    // Stage 2 only takes a value computed from loaded operands and a known operation
    resultFromLoaded: assert property (@(posedge clk) disable iff (!rstN)
        loadResult |-> !$isunknown({aluOp, aReg, bReg}));

endmodule

//--- logic/barrelShifter.sv
// Logarithmic barrel shifter for logical shifts and rotates
module barrelShifter import isaPkg::*; (
    input  logic [DataWidth-1:0]  dataIn,
    input  logic [ShiftWidth-1:0] amount,
    input  shiftModeE             mode,
    output logic [DataWidth-1:0]  dataOut
);

    logic [DataWidth-1:0] level [0:ShiftWidth];

    assign level[0] = dataIn;

    // Level k moves by 2**k when amount[k] is set
    for (genvar k = 0; k < ShiftWidth; k++) begin : gLevel
        localparam int Dist = 1 << k;
        logic [DataWidth-1:0] moved;

        always_comb begin
            moved = level[k];
            case (mode)
                modeSll: moved = {level[k][DataWidth-Dist-1:0], {Dist{1'b0}}};
                modeSrl: moved = {{Dist{1'b0}}, level[k][DataWidth-1:Dist]};
                modeRol: begin
                    moved = {level[k][DataWidth-Dist-1:0], level[k][DataWidth-1:DataWidth-Dist]};
                end
                modeRor: moved = {level[k][Dist-1:0], level[k][DataWidth-1:Dist]};
                default: moved = level[k];
            endcase
        end

        assign level[k+1] = amount[k] ? moved : level[k];
    end

    assign dataOut = level[ShiftWidth];

endmodule

//--- logic/claAdder.sv
// Carry-lookahead adder with 4-bit lookahead groups and signed overflow
module claAdder import isaPkg::*; (
    input  logic [DataWidth-1:0] inA,
    input  logic [DataWidth-1:0] inB,
    input  logic                 cIn,
    output logic [DataWidth-1:0] sum,
    output logic                 cOut,
    output logic                 overflow
);

    logic [DataWidth-1:0] gen;
    logic [DataWidth-1:0] prop;
    logic [DataWidth:0]   carry;
    logic [3:0]           grpGen;   // Four groups of four bits
    logic [3:0]           grpProp;

    assign gen  = inA & inB;
    assign prop = inA ^ inB;

    for (genvar k = 0; k < 4; k++) begin : gGroup
        localparam int Base = 4 * k;

        assign grpProp[k] = &prop[Base+3:Base];
        assign grpGen[k]  = gen[Base+3] | (prop[Base+3] & gen[Base+2])
                          | (prop[Base+3] & prop[Base+2] & gen[Base+1])
                          | (prop[Base+3] & prop[Base+2] & prop[Base+1] & gen[Base]);

        // Carries inside the group from its own carry in
        assign carry[Base+1] = gen[Base] | (prop[Base] & carry[Base]);
        assign carry[Base+2] = gen[Base+1] | (prop[Base+1] & gen[Base])
                             | (prop[Base+1] & prop[Base] & carry[Base]);
        assign carry[Base+3] = gen[Base+2] | (prop[Base+2] & gen[Base+1])
                             | (prop[Base+2] & prop[Base+1] & gen[Base])
                             | (prop[Base+2] & prop[Base+1] & prop[Base] & carry[Base]);
    end

    assign carry[0]  = cIn;
    assign carry[4]  = grpGen[0] | (grpProp[0] & cIn);
    assign carry[8]  = grpGen[1] | (grpProp[1] & grpGen[0]) | (grpProp[1] & grpProp[0] & cIn);
    assign carry[12] = grpGen[2] | (grpProp[2] & grpGen[1]) | (grpProp[2] & grpProp[1] & grpGen[0])
                     | (grpProp[2] & grpProp[1] & grpProp[0] & cIn);
    assign carry[16] = grpGen[3] | (grpProp[3] & grpGen[2]) | (grpProp[3] & grpProp[2] & grpGen[1])
                     | (grpProp[3] & grpProp[2] & grpProp[1] & grpGen[0])
                     | (grpProp[3] & grpProp[2] & grpProp[1] & grpProp[0] & cIn);

    assign sum      = prop ^ carry[DataWidth-1:0];
    assign cOut     = carry[DataWidth];
    assign overflow = carry[DataWidth] ^ carry[DataWidth-1];  // Carry into and out of sign bit differ

endmodule

//--- logic/execCtrl.sv
// Execute control with opcode and funct decode, stage valid bits and valid/ready handshake checks
module execCtrl import isaPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  opcodeE                opcode,
    input  logic [FunctWidth-1:0] funct,
    input  logic                  outReady,
    output logic                  inReady,
    output logic                  outValid,
    output logic                  illegal,
    output logic                  loadOperands,
    output logic                  loadResult,
    output aluOpE                 aluOp
);

    logic  stage1Valid;
    logic  stage1Illegal;
    logic  runEnable;    // Low in reset, high from the first edge after it
    aluOpE decOp;
    logic  decIllegal;

    always_comb begin
        decOp      = opZero;
        decIllegal = 1'b0;
        case (opcode)
            opcNop:   decOp = opZero;
            opcAddi:  decOp = opAdd;
            opcSubi:  decOp = opSub;
            opcXori:  decOp = opXor;
            opcNandi: decOp = opNand;
            opcSlli:  decOp = opSll;
            opcSrli:  decOp = opSrl;
            opcRoli:  decOp = opRol;
            opcRori:  decOp = opRor;
            opcShiftReg: begin
                case (funct)
                    2'b00:   decOp = opSll;
                    2'b01:   decOp = opSrl;
                    2'b10:   decOp = opRol;
                    default: decOp = opRor;
                endcase
            end
            opcArithReg: begin
                case (funct)
                    2'b00:   decOp = opAdd;
                    2'b01:   decOp = opSub;
                    2'b10:   decOp = opXor;
                    default: decOp = opNand;
                endcase
            end
            opcSeq: decOp = opSeq;
            opcSlt: decOp = opSlt;
            opcSle: decOp = opSle;
            opcSco: decOp = opSco;
            default: decIllegal = (opcode[OpcodeWidth-1 -: 3] != 3'b000);  // Whole NOP class is legal
        endcase
    end

    // Stage 2 moves when it is empty or being taken
    assign loadResult   = stage1Valid && (!outValid || outReady);
    assign inReady      = runEnable && (!stage1Valid || loadResult);
    assign loadOperands = inValid && inReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            runEnable     <= 1'b0;
            stage1Valid   <= 1'b0;
            stage1Illegal <= 1'b0;
            aluOp         <= opZero;
            outValid      <= 1'b0;
            illegal       <= 1'b0;
        end else begin
            runEnable <= 1'b1;
            if (loadOperands) begin
                stage1Valid   <= 1'b1;
                stage1Illegal <= decIllegal;
                aluOp         <= decOp;  // Stage-1 operation seen by the datapath
            end else if (loadResult) begin
                stage1Valid <= 1'b0;
            end
            if (loadResult) begin
                outValid <= 1'b1;
                illegal  <= stage1Illegal;
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    // Caller holds the instruction while it waits for inReady
    inputHeld: assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> inValid && $stable(opcode) && $stable(funct));
    illegalHeld: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> $stable(illegal));

endmodule

//--- logic/execUnit.sv
// Execute stage top: control and datapath instances with their connecting wires
module execUnit import isaPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  opcodeE                opcode,
    input  logic [FunctWidth-1:0] funct,
    input  logic [DataWidth-1:0]  aIn,
    input  logic [DataWidth-1:0]  bIn,
    input  logic                  outReady,
    output logic                  inReady,
    output logic                  outValid,
    output logic [DataWidth-1:0]  result,
    output logic                  illegal
);

    logic  loadOperands;
    logic  loadResult;
    aluOpE aluOp;   // Stage-1 operation

    execCtrl ctrl (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .opcode       (opcode),
        .funct        (funct),
        .outReady     (outReady),
        .inReady      (inReady),
        .outValid     (outValid),
        .illegal      (illegal),
        .loadOperands (loadOperands),
        .loadResult   (loadResult),
        .aluOp        (aluOp)
    );

    aluCore alu (
        .clk          (clk),
        .rstN         (rstN),
        .loadOperands (loadOperands),
        .loadResult   (loadResult),
        .aluOp        (aluOp),
        .aIn          (aIn),
        .bIn          (bIn),
        .result       (result)
    );

endmodule

//--- logic/isaPkg.sv
// Widths, opcode encodings, decoded ALU operations and shifter modes for the execute stage
package isaPkg;

    localparam int DataWidth   = 16;  // Operand and result width
    localparam int ShiftWidth  = 4;   // Shift amount from low bits of B
    localparam int OpcodeWidth = 5;
    localparam int FunctWidth  = 2;

    // Top three bits give the class; jump, branch and memory classes are left out here
    typedef enum logic [OpcodeWidth-1:0] {
        opcNop      = 5'b00000,
        opcAddi     = 5'b01000,
        opcSubi     = 5'b01001,
        opcXori     = 5'b01010,
        opcNandi    = 5'b01011,
        opcSlli     = 5'b10100,
        opcSrli     = 5'b10101,
        opcRoli     = 5'b10110,
        opcRori     = 5'b10111,
        opcShiftReg = 5'b11010,  // Funct picks SLL, SRL, ROL, ROR
        opcArithReg = 5'b11011,  // Funct picks ADD, SUB, XOR, NAND
        opcSeq      = 5'b11100,
        opcSlt      = 5'b11101,
        opcSle      = 5'b11110,
        opcSco      = 5'b11111
    } opcodeE;

    typedef enum logic [3:0] {
        opZero,  // NOP and illegal classes
        opAdd,
        opSub,   // B minus A
        opXor,
        opNand,
        opSll,
        opSrl,
        opRol,
        opRor,
        opSeq,
        opSlt,
        opSle,
        opSco    // Carry out of A plus B
    } aluOpE;

    typedef enum logic [1:0] {
        modeSll,
        modeSrl,
        modeRol,
        modeRor
    } shiftModeE;

endpackage
